//--- design/axil_host_port.sv
// ======================================================================
// AXI4-Lite slave front end. Accepts write and read transactions into
// the request queue, writes first, and returns queued responses in
// order on the B and R channels.
// ======================================================================

`include "ics32_params.svh"

module axil_host_port
    import ics32_pkg::*;
(
    input  logic                        vdp_clk,
    input  logic                        vdp_reset,

    // write address and data
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`ICS32_ADDR_W-1:0]    awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [`ICS32_DATA_W-1:0]    wdata,
    input  logic [`ICS32_DATA_W/8-1:0]  wstrb,

    // write response
    output logic                        bvalid,
    input  logic                        bready,
    output logic [1:0]                  bresp,

    // read address and data
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [`ICS32_ADDR_W-1:0]    araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [`ICS32_DATA_W-1:0]    rdata,
    output logic [1:0]                  rresp,

    // request queue
    input  logic                        req_full,
    output logic                        req_push,
    output mmio_req_t                   req_data,

    // response queue
    input  logic                        rsp_empty,
    input  mmio_rsp_t                   rsp_head,
    output logic                        rsp_pop
);

    logic can_accept;
    logic wr_accept;
    logic rd_accept;

    // the request is registered, so a pending push still has to land
    // before the full flag can be trusted again
    assign can_accept = !req_full && !req_push;

    // AW and W must both be present; a write blocks a read that cycle
    assign wr_accept = awvalid && wvalid && can_accept;
    assign rd_accept = arvalid && can_accept && !wr_accept;

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign arready = rd_accept;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            req_push <= 1'b0;
        end else begin
            req_push <= wr_accept || rd_accept;
        end
    end

    // pack the accepted transaction
    always_ff @(posedge vdp_clk) begin
        if (wr_accept) begin
            req_data.write <= 1'b1;
            req_data.addr  <= awaddr;
            req_data.wdata <= wdata;
            req_data.wstrb <= wstrb;
        end else if (rd_accept) begin
            req_data.write <= 1'b0;
            req_data.addr  <= araddr;
            req_data.wdata <= '0;
            req_data.wstrb <= '0;
        end
    end

    // head of the response queue goes to B or R by its write flag
    assign bvalid = !rsp_empty && rsp_head.write;
    assign rvalid = !rsp_empty && !rsp_head.write;

    assign bresp = rsp_head.resp;
    assign rresp = rsp_head.resp;
    assign rdata = rsp_head.rdata;

    // drop the head once its channel has transferred
    assign rsp_pop = (bvalid && bready) || (rvalid && rready);

endmodule

//--- design/ics32_periph_top.sv
// ======================================================================
// peripheral bus top level: AXI4-Lite host port, request and response
// queues, and the peripheral register block on vdp_clk
// ======================================================================

`include "ics32_params.svh"

module ics32_periph_top
    import ics32_pkg::*;
(
    input  logic                        vdp_clk,
    input  logic                        vdp_reset,

    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`ICS32_ADDR_W-1:0]    awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [`ICS32_DATA_W-1:0]    wdata,
    input  logic [`ICS32_DATA_W/8-1:0]  wstrb,
    output logic                        bvalid,
    input  logic                        bready,
    output logic [1:0]                  bresp,
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [`ICS32_ADDR_W-1:0]    araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [`ICS32_DATA_W-1:0]    rdata,
    output logic [1:0]                  rresp,

    input  logic                        btn1,
    input  logic                        btn2,
    input  logic                        btn3,
    output logic                        led_r,
    output logic                        led_b
);

    logic      req_push;
    logic      req_pop;
    logic      req_full;
    logic      req_empty;
    mmio_req_t req_in;
    mmio_req_t req_head;

    logic      rsp_push;
    logic      rsp_pop;
    logic      rsp_full;
    logic      rsp_empty;
    mmio_rsp_t rsp_in;
    mmio_rsp_t rsp_head;

    axil_host_port host_port (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .req_full  (req_full),
        .req_push  (req_push),
        .req_data  (req_in),
        .rsp_empty (rsp_empty),
        .rsp_head  (rsp_head),
        .rsp_pop   (rsp_pop)
    );

    mmio_fifo #(
        .payload_t (mmio_req_t),
        .DEPTH     (`ICS32_REQ_DEPTH)
    ) req_fifo (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .push      (req_push),
        .push_data (req_in),
        .pop       (req_pop),
        .pop_data  (req_head),
        .full      (req_full),
        .empty     (req_empty)
    );

    mmio_fifo #(
        .payload_t (mmio_rsp_t),
        .DEPTH     (`ICS32_RESP_DEPTH)
    ) rsp_fifo (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .push      (rsp_push),
        .push_data (rsp_in),
        .pop       (rsp_pop),
        .pop_data  (rsp_head),
        .full      (rsp_full),
        .empty     (rsp_empty)
    );

    mmio_peripherals periph (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .req_empty (req_empty),
        .req_head  (req_head),
        .req_pop   (req_pop),
        .rsp_full  (rsp_full),
        .rsp_push  (rsp_push),
        .rsp_data  (rsp_in),
        .btn1      (btn1),
        .btn2      (btn2),
        .btn3      (btn3),
        .led_r     (led_r),
        .led_b     (led_b)
    );

endmodule

//--- design/ics32_pkg.sv
// ======================================================================
// request and response types passed between the AXI4-Lite host port,
// the two queues and the peripheral block
// ======================================================================

`include "ics32_params.svh"

package ics32_pkg;

    // AXI response encodings
    typedef enum logic [1:0] {
        MMIO_OKAY   = 2'b00,
        MMIO_DECERR = 2'b11
    } mmio_resp_e;

    // one accepted bus transaction
    typedef struct packed {
        logic                        write;
        logic [`ICS32_ADDR_W-1:0]    addr;
        logic [`ICS32_DATA_W-1:0]    wdata;
        logic [`ICS32_DATA_W/8-1:0]  wstrb;
    } mmio_req_t;

    // one completed transaction, write flag steers it to B or R
    typedef struct packed {
        logic                        write;
        logic [`ICS32_DATA_W-1:0]    rdata;
        mmio_resp_e                  resp;
    } mmio_rsp_t;

endpackage

//--- design/mmio_fifo.sv
// ======================================================================
// synchronous FIFO with the payload type as a parameter. Used for both
// the request queue and the response queue. Push on full and pop on
// empty are ignored; the head is read combinationally.
// ======================================================================

`include "ics32_params.svh"

module mmio_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `ICS32_REQ_DEPTH
) (
    input  logic     vdp_clk,
    input  logic     vdp_reset,

    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,

    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign pop_data = mem[rd_ptr];

    always_ff @(posedge vdp_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at DEPTH so any depth works
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/mmio_peripherals.sv
// ======================================================================
// peripheral register block: status LEDs, signed 16x16 DSP multiplier
// and a three-button gamepad mock. Pops one request at a time and
// pushes its response on the following cycle.
// ======================================================================

`include "ics32_params.svh"

module mmio_peripherals
    import ics32_pkg::*;
(
    input  logic      vdp_clk,
    input  logic      vdp_reset,

    input  logic      req_empty,
    input  mmio_req_t req_head,
    output logic      req_pop,

    input  logic      rsp_full,
    output logic      rsp_push,
    output mmio_rsp_t rsp_data,

    input  logic      btn1,
    input  logic      btn2,
    input  logic      btn3,

    output logic      led_r,
    output logic      led_b
);

    logic                     hit_status;
    logic                     hit_dsp_a;
    logic                     hit_dsp_b;
    logic                     hit_pad;
    logic                     hit_any;
    logic                     wr_en;
    logic [`ICS32_DATA_W-1:0] read_data;

    logic [1:0]               status;
    logic [15:0]              dsp_a;
    logic [15:0]              dsp_b;
    logic [15:0]              dsp_a_next;
    logic [15:0]              dsp_b_next;
    logic [31:0]              dsp_result;
    logic [1:0]               pad_ctrl;
    logic [1:0]               pad_ctrl_next;
    logic [7:0]               pad_state;

    // byte lanes 0 and 1 of a 16-bit operand
    function automatic logic [15:0] merge_low_half(
        input logic [15:0]                old_val,
        input logic [`ICS32_DATA_W-1:0]   data,
        input logic [`ICS32_DATA_W/8-1:0] strb
    );
        logic [15:0] merged;
        merged = old_val;
        if (strb[0]) begin
            merged[7:0] = data[7:0];
        end
        if (strb[1]) begin
            merged[15:8] = data[15:8];
        end
        return merged;
    endfunction

    // only take a request when its response has somewhere to go
    // and the previous registered push has already landed
    assign req_pop = !req_empty && !rsp_full && !rsp_push;
    assign wr_en   = req_pop && req_head.write;

    assign hit_status = (req_head.addr == `ICS32_ADDR_STATUS);
    assign hit_dsp_a  = (req_head.addr == `ICS32_ADDR_DSP_A);
    assign hit_dsp_b  = (req_head.addr == `ICS32_ADDR_DSP_B);
    assign hit_pad    = (req_head.addr == `ICS32_ADDR_PAD);
    assign hit_any    = hit_status || hit_dsp_a || hit_dsp_b || hit_pad;

    // next-state values, so a read popped right after a write sees it
    always_comb begin
        dsp_a_next    = dsp_a;
        dsp_b_next    = dsp_b;
        pad_ctrl_next = pad_ctrl;
        if (wr_en && hit_dsp_a) begin
            dsp_a_next = merge_low_half(dsp_a, req_head.wdata, req_head.wstrb);
        end
        if (wr_en && hit_dsp_b) begin
            dsp_b_next = merge_low_half(dsp_b, req_head.wdata, req_head.wstrb);
        end
        if (wr_en && hit_pad && req_head.wstrb[0]) begin
            pad_ctrl_next = req_head.wdata[1:0];
        end
    end

    // status register, reset lights the red LED
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= 2'b01;
        end else if (wr_en && hit_status && req_head.wstrb[0]) begin
            status <= req_head.wdata[1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

    // signed multiply, result follows the operand write by one cycle
    always_ff @(posedge vdp_clk) begin
        dsp_a      <= dsp_a_next;
        dsp_b      <= dsp_b_next;
        dsp_result <= $signed(dsp_a_next) * $signed(dsp_b_next);
    end

    // gamepad mock: latch loads buttons, rising clock bit shifts right
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl  <= 2'b00;
            pad_state <= 8'h00;
        end else begin
            pad_ctrl <= pad_ctrl_next;
            if (pad_ctrl_next[0]) begin
                pad_state <= {btn1, btn3, 5'b0, btn2};
            end
            if (pad_ctrl_next[1] && !pad_ctrl[1]) begin
                pad_state <= {1'b0, pad_state[7:1]};
            end
        end
    end

    // read mux, unmapped and write responses carry zero data
    always_comb begin
        read_data = '0;
        if (!req_head.write) begin
            if (hit_status) begin
                read_data = {30'b0, status};
            end else if (hit_dsp_a || hit_dsp_b) begin
                read_data = dsp_result;
            end else if (hit_pad) begin
                read_data = {31'b0, pad_state[0]};
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            rsp_push <= 1'b0;
        end else begin
            rsp_push <= req_pop;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (req_pop) begin
            rsp_data.write <= req_head.write;
            rsp_data.rdata <= read_data;
            rsp_data.resp  <= hit_any ? MMIO_OKAY : MMIO_DECERR;
        end
    end

endmodule

//--- ics32_periph.f
+incdir+include
design/ics32_pkg.sv
design/mmio_fifo.sv
design/axil_host_port.sv
design/mmio_peripherals.sv
design/ics32_periph_top.sv
sim/tb_ics32_periph.sv

//--- include/ics32_params.svh
// ======================================================================
// shared bus widths, FIFO depths and register address map for the
// peripheral bus, included by the package and by every RTL module
// ======================================================================

`ifndef ICS32_PARAMS_SVH
`define ICS32_PARAMS_SVH

// bus widths
`define ICS32_ADDR_W 8
`define ICS32_DATA_W 32

// request and response queue depths
`define ICS32_REQ_DEPTH 4
`define ICS32_RESP_DEPTH 4

// register map, byte addresses
`define ICS32_ADDR_STATUS 8'h00
`define ICS32_ADDR_DSP_A 8'h10
`define ICS32_ADDR_DSP_B 8'h14
`define ICS32_ADDR_PAD 8'h20

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the peripheral bus testbench with Verilator, runs it and
# decides pass or fail by searching the simulation log.
set -u

ROOT="$(cd "$(dirname "$0")" && pwd)"
BUILD_DIR="build"
LOG="$BUILD_DIR/sim.log"
FAIL_MSG="Checks failed"

cd "$ROOT" || { echo "cannot enter project root"; exit 1; }

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "cannot create $BUILD_DIR"
    exit 1
fi

verilator --binary --timing -Wno-fatal \
    -f ics32_periph.f \
    --top-module tb_ics32_periph \
    --Mdir "$BUILD_DIR/obj" -o sim_bin
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/obj/sim_bin" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

//--- sim/periph_trace.txt
// op: 0 write, 1 read, 2 LED check {led_b,led_r}, 3 write+read same cycle, 4 pad clock pulse, F end
// columns: op addr data strb btns(btn3 btn2 btn1) exp_data exp_resp burst
2 00 00000000 0 0 00000001 0 0
0 00 00000002 F 0 00000000 0 0
2 00 00000000 0 0 00000002 0 0
1 00 00000000 0 0 00000002 0 0
// DSP multiplier, signed and maximum operands, strobe handling
0 10 0000FFFD F 0 00000000 0 0
0 14 00000007 F 0 00000000 0 0
1 10 00000000 0 0 FFFFFFEB 0 0
0 10 00007FFF F 0 00000000 0 0
0 14 00007FFF F 0 00000000 0 0
1 10 00000000 0 0 3FFF0001 0 0
0 14 00008000 F 0 00000000 0 0
1 14 00000000 0 0 C0008000 0 0
0 10 00001234 0 0 00000000 0 0
1 10 00000000 0 0 C0008000 0 0
0 10 0000AB02 1 0 00000000 0 0
1 10 00000000 0 0 C07F0000 0 0
// gamepad, btn2 and btn3 pressed
0 20 00000001 F 6 00000000 0 0
0 20 00000000 F 6 00000000 0 0
1 20 00000000 0 6 00000001 0 0
4 20 00000000 F 6 00000000 0 0
1 20 00000000 0 6 00000000 0 0
4 20 00000000 F 6 00000000 0 0
4 20 00000000 F 6 00000000 0 0
4 20 00000000 F 6 00000000 0 0
4 20 00000000 F 6 00000000 0 0
4 20 00000000 F 6 00000000 0 0
1 20 00000000 0 6 00000001 0 0
4 20 00000000 F 6 00000000 0 0
1 20 00000000 0 6 00000000 0 0
// unmapped address
0 30 00000003 F 0 00000000 3 0
1 30 00000000 0 0 00000000 3 0
1 00 00000000 0 0 00000002 0 0
2 00 00000000 0 0 00000002 0 0
// burst under back-pressure
1 00 00000000 0 0 00000002 0 1
1 10 00000000 0 0 C07F0000 0 1
1 30 00000000 0 0 00000000 3 1
1 20 00000000 0 0 00000000 0 1
0 00 00000003 F 0 00000000 0 1
1 00 00000000 0 0 00000003 0 1
// write and read offered together
3 00 00000001 F 0 00000001 0 0
3 14 00000002 F 0 0000FE04 0 0
2 00 00000000 0 0 00000001 0 0
F 00 00000000 0 0 00000000 0 0

//--- sim/tb_ics32_periph.sv
// ======================================================================
// testbench for the peripheral bus top level. Replays the transaction
// trace over AXI4-Lite, holds B and R ready low after burst lines and
// checks read data, response codes and LEDs in request order.
// ======================================================================

`include "ics32_params.svh"

module tb_ics32_periph
    import ics32_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TRACE_COLS  = 8;
    localparam int TRACE_LINES = 64;

    logic                        vdp_clk;
    logic                        vdp_reset;
    logic                        awvalid;
    logic                        awready;
    logic [`ICS32_ADDR_W-1:0]    awaddr;
    logic                        wvalid;
    logic                        wready;
    logic [`ICS32_DATA_W-1:0]    wdata;
    logic [`ICS32_DATA_W/8-1:0]  wstrb;
    logic                        bvalid;
    logic                        bready;
    logic [1:0]                  bresp;
    logic                        arvalid;
    logic                        arready;
    logic [`ICS32_ADDR_W-1:0]    araddr;
    logic                        rvalid;
    logic                        rready;
    logic [`ICS32_DATA_W-1:0]    rdata;
    logic [1:0]                  rresp;
    logic                        btn1;
    logic                        btn2;
    logic                        btn3;
    logic                        led_r;
    logic                        led_b;

    logic [31:0]                 trace_mem [TRACE_COLS*TRACE_LINES];
    int                          n_lines;
    int                          error_count;
    int                          check_count;
    integer                      seed;

    // responses still owed by the DUT, oldest first
    bit                          pend_write [$];
    logic [`ICS32_DATA_W-1:0]    pend_data [$];
    mmio_resp_e                  pend_resp [$];
    string                       pend_name [$];

    ics32_periph_top UUT (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .btn1      (btn1),
        .btn2      (btn2),
        .btn3      (btn3),
        .led_r     (led_r),
        .led_b     (led_b)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #4 vdp_clk = ~vdp_clk;
    end

    // watchdog, budget scales with the trace length
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 200) @(posedge vdp_clk);
        $display("timeout: trace did not finish within %0d cycles", n_lines * 200);
        $display("Checks failed");
        $finish;
    end

    task automatic check_rdata(input string name, input logic [`ICS32_DATA_W-1:0] exp_val,
                               input logic [`ICS32_DATA_W-1:0] act_val);
        check_count++;
        if (act_val !== exp_val) begin
            error_count++;
            $display("CHECK FAILED %s rdata: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic check_resp(input string name, input mmio_resp_e exp_val,
                              input mmio_resp_e act_val);
        check_count++;
        if (act_val !== exp_val) begin
            error_count++;
            $display("CHECK FAILED %s resp: expected %b, actual %b", name, exp_val, act_val);
        end
    endtask

    task automatic check_leds(input string name, input logic [1:0] exp_val,
                              input logic [1:0] act_val);
        check_count++;
        if (act_val !== exp_val) begin
            error_count++;
            $display("CHECK FAILED %s leds: expected %b, actual %b", name, exp_val, act_val);
        end
    endtask

    task automatic expect_rsp(input bit is_write, input logic [`ICS32_DATA_W-1:0] data,
                              input mmio_resp_e resp, input string name);
        pend_write.push_back(is_write);
        pend_data.push_back(data);
        pend_resp.push_back(resp);
        pend_name.push_back(name);
    endtask

    // present AW/W and/or AR on the next edge, hold each until accepted
    task automatic issue(input bit do_wr, input bit do_rd,
                         input logic [`ICS32_ADDR_W-1:0] addr,
                         input logic [`ICS32_DATA_W-1:0] data,
                         input logic [`ICS32_DATA_W/8-1:0] strb, input string name);
        bit aw_done;
        bit ar_done;
        bit aw_now;
        bit ar_now;
        aw_done = !do_wr;
        ar_done = !do_rd;
        @(posedge vdp_clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        araddr  <= addr;
        awvalid <= do_wr;
        wvalid  <= do_wr;
        arvalid <= do_rd;
        while (!(aw_done && ar_done)) begin
            @(negedge vdp_clk);
            aw_now = awvalid && awready && wready;
            ar_now = arvalid && arready;
            if (ar_now && !aw_done) begin
                error_count++;
                $display("ERROR %s: read was accepted before the write offered with it", name);
            end
            @(posedge vdp_clk);
            if (aw_now) begin
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
                aw_done = 1'b1;
            end
            if (ar_now) begin
                arvalid <= 1'b0;
                ar_done = 1'b1;
            end
        end
    endtask

    // back-pressure for a stretch, then take every pending response in order
    task automatic collect_responses(input int stretch);
        bit                       exp_write;
        logic [`ICS32_DATA_W-1:0] exp_data;
        mmio_resp_e               exp_resp;
        string                    name;
        repeat (stretch + 1) @(posedge vdp_clk);
        bready <= 1'b1;
        rready <= 1'b1;
        while (pend_name.size() > 0) begin
            @(negedge vdp_clk);
            if (bvalid || rvalid) begin
                exp_write = pend_write.pop_front();
                exp_data  = pend_data.pop_front();
                exp_resp  = pend_resp.pop_front();
                name      = pend_name.pop_front();
                if (exp_write != bvalid) begin
                    error_count++;
                    $display("ERROR %s: response came back on the wrong channel", name);
                end else if (exp_write) begin
                    check_resp(name, exp_resp, mmio_resp_e'(bresp));
                end else begin
                    check_rdata(name, exp_data, rdata);
                    check_resp(name, exp_resp, mmio_resp_e'(rresp));
                end
            end
            @(posedge vdp_clk);
        end
        bready <= 1'b0;
        rready <= 1'b0;
        // nothing may be left over once every request is answered
        @(negedge vdp_clk);
        if (bvalid || rvalid) begin
            error_count++;
            $display("ERROR a response arrived that no request asked for");
        end
    endtask

    initial begin
        int          i;
        int          base;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] strb;
        logic [31:0] btns;
        logic [31:0] exp_data;
        logic [31:0] exp_resp;
        logic [31:0] burst;
        string       name;

        vdp_reset   = 1'b1;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        btn1        = 1'b0;
        btn2        = 1'b0;
        btn3        = 1'b0;
        seed        = 35;
        error_count = 0;
        check_count = 0;
        n_lines     = 0;

        // unfilled words read as the end marker
        for (i = 0; i < TRACE_COLS * TRACE_LINES; i++) begin
            trace_mem[i] = 32'h0000_000F;
        end
        $readmemh("sim/periph_trace.txt", trace_mem);
        while (n_lines < TRACE_LINES && trace_mem[n_lines * TRACE_COLS] != 32'hF) begin
            n_lines++;
        end

        repeat (8) @(posedge vdp_clk);
        vdp_reset <= 1'b0;
        @(negedge vdp_clk);
        if (awready || wready || arready || bvalid || rvalid) begin
            error_count++;
            $display("ERROR a handshake output is high right after reset");
        end
        if (n_lines == 0) begin
            error_count++;
            $display("ERROR the trace file held no transactions");
        end

        for (i = 0; i < n_lines; i++) begin
            base     = i * TRACE_COLS;
            op       = trace_mem[base];
            addr     = trace_mem[base + 1];
            data     = trace_mem[base + 2];
            strb     = trace_mem[base + 3];
            btns     = trace_mem[base + 4];
            exp_data = trace_mem[base + 5];
            exp_resp = trace_mem[base + 6];
            burst    = trace_mem[base + 7];
            name     = $sformatf("trace line %0d", i + 1);

            @(posedge vdp_clk);
            btn1 <= btns[0];
            btn2 <= btns[1];
            btn3 <= btns[2];

            if (burst[0] && (op == 0 || op == 1)) begin
                // queue it, responses are taken later under back-pressure
                issue(op == 0, op == 1, addr[7:0], data, strb[3:0], name);
                expect_rsp(op == 0, exp_data, mmio_resp_e'(exp_resp[1:0]), name);
            end else begin
                if (pend_name.size() > 0) begin
                    collect_responses(1 + ($random(seed) & 15));
                end
                case (op)
                    0, 1: begin
                        issue(op == 0, op == 1, addr[7:0], data, strb[3:0], name);
                        expect_rsp(op == 0, exp_data, mmio_resp_e'(exp_resp[1:0]), name);
                        collect_responses(0);
                    end
                    2: begin
                        @(negedge vdp_clk);
                        check_leds(name, exp_data[1:0], {led_b, led_r});
                    end
                    3: begin
                        // writes win the same-cycle race, so B comes first
                        issue(1'b1, 1'b1, addr[7:0], data, strb[3:0], name);
                        expect_rsp(1'b1, '0, MMIO_OKAY, name);
                        expect_rsp(1'b0, exp_data, mmio_resp_e'(exp_resp[1:0]), name);
                        collect_responses(0);
                    end
                    4: begin
                        issue(1'b1, 1'b0, addr[7:0], 32'h2, strb[3:0], name);
                        expect_rsp(1'b1, '0, mmio_resp_e'(exp_resp[1:0]), name);
                        collect_responses(0);
                        issue(1'b1, 1'b0, addr[7:0], 32'h0, strb[3:0], name);
                        expect_rsp(1'b1, '0, mmio_resp_e'(exp_resp[1:0]), name);
                        collect_responses(0);
                    end
                    default: begin
                        error_count++;
                        $display("ERROR %s: unknown operation code %h", name, op);
                    end
                endcase
            end
        end
        if (pend_name.size() > 0) begin
            collect_responses(1 + ($random(seed) & 15));
        end

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
